/* rtl/track_width_pkg.sv */
// Data widths and vector types of the correlator envelope datapath.
`default_nettype none

package track_width_pkg;

   // One signed correlator accumulation.
   localparam int ACC_WIDTH = 19;

   // Absolute value of an accumulation, saturated at the top.
   localparam int MAG_WIDTH = ACC_WIDTH - 1;

   // Sum of the squares of two magnitudes.
   localparam int ENERGY_WIDTH = 2 * MAG_WIDTH + 1;

   // Square root of the energy, taken over an even number of bits.
   localparam int ENV_WIDTH = (ENERGY_WIDTH + 1) / 2;

   localparam int TAG_WIDTH = 2;

   // Tag, then early, prompt and late I/Q.
   localparam int ACC_SET_WIDTH = TAG_WIDTH + 6 * ACC_WIDTH;

   typedef logic signed [ACC_WIDTH-1:0] acc_t;
   typedef logic [MAG_WIDTH-1:0]        mag_t;
   typedef logic [ENERGY_WIDTH-1:0]     energy_t;
   typedef logic [ENV_WIDTH-1:0]        env_t;
   typedef logic [TAG_WIDTH-1:0]        tag_t;

endpackage

`default_nettype wire

/* rtl/track_ctrl_pkg.sv */
// Sequencing constants and state types of the tracking update.
`default_nettype none

package track_ctrl_pkg;

   // Accumulation sets waiting for an update.
   localparam int FIFO_DEPTH = 4;

   // Early, prompt and late.
   localparam int SUBCH_COUNT = 3;

   // One result bit per iteration.
   localparam int ROOT_ITERS = track_width_pkg::ENV_WIDTH;

   typedef enum logic [1:0] {
      IDLE,
      ISSUE,
      DRAIN,
      ROOT
   } seq_state_t;

   // 0 is early, 1 is prompt, 2 is late.
   typedef logic [1:0] subch_t;

endpackage

`default_nettype wire

/* rtl/acc_fifo.sv */
// Show-ahead FIFO of tagged accumulation sets with an overflow pulse.
`timescale 1ns/1ps
`default_nettype none

module acc_fifo (
   input  wire                                         i_arst_n,
   input  wire                                         clk,
   input  wire                                         i_push,
   input  wire  [track_width_pkg::ACC_SET_WIDTH-1:0]   i_data,
   input  wire                                         i_pop,
   output logic [track_width_pkg::ACC_SET_WIDTH-1:0]   o_head,
   output logic                                        o_empty,
   output logic                                        o_overflow
);
   import track_width_pkg::*;
   import track_ctrl_pkg::*;

   logic [ACC_SET_WIDTH-1:0]        mem [FIFO_DEPTH];
   logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
   logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
   logic [$clog2(FIFO_DEPTH+1)-1:0] count;
   logic                            full;
   logic                            do_push;
   logic                            do_pop;

   assign full    = (count == FIFO_DEPTH);
   assign o_empty = (count == '0);

   // A pop in the same cycle frees the slot for a push on a full FIFO.
   assign do_push = i_push && (!full || i_pop);
   assign do_pop  = i_pop && !o_empty;

   // Head is read without latency.
   assign o_head = mem[rd_ptr];

   //////////////////////////////
   // Pointers and fill level
   //////////////////////////////

   // Depth is a power of two, so the pointers wrap by themselves.
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         o_overflow <= 1'b0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // Set is lost.
         o_overflow <= i_push && full && !i_pop;
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= i_data;
      end
   end

   // The sequencer only pops a set it has issued from the head.
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_pop |-> !o_empty)
      else $error("acc_fifo: pop while empty");

endmodule

`default_nettype wire

/* rtl/update_sequencer.sv */
// FSM that runs one tracking update at a time over the three subchannels.
`timescale 1ns/1ps
`default_nettype none

module update_sequencer (
   input  wire                     clk,
   input  wire                     i_arst_n,
   input  wire                     i_fifo_empty,
   input  wire                     i_energy_done,
   input  wire                     i_root_last,
   output logic                    o_pop,
   output logic                    o_issue,
   output track_ctrl_pkg::subch_t  o_subch,
   output logic                    o_capture_tag,
   output logic                    o_root_start,
   output logic                    o_env_valid
);
   import track_ctrl_pkg::*;

   seq_state_t state;
   seq_state_t state_nxt;
   subch_t     subch;
   logic       last_subch;

   assign last_subch = (subch == subch_t'(SUBCH_COUNT - 1));

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (!i_fifo_empty) begin
               state_nxt = ISSUE;
            end
         end
         ISSUE: begin
            if (last_subch) begin
               state_nxt = DRAIN;
            end
         end
         DRAIN: begin
            if (i_energy_done) begin
               state_nxt = ROOT;
            end
         end
         default: begin
            if (i_root_last) begin
               state_nxt = IDLE;
            end
         end
      endcase
   end

   // Subchannel counter wraps back to early after the late issue.
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state       <= IDLE;
         subch       <= '0;
         o_env_valid <= 1'b0;
      end else begin
         state       <= state_nxt;
         o_env_valid <= (state == ROOT) && i_root_last;
         if (state == ISSUE) begin
            subch <= last_subch ? '0 : subch + 1'b1;
         end
      end
   end

   assign o_issue       = (state == ISSUE);
   assign o_subch       = subch;
   assign o_capture_tag = o_issue && (subch == '0);
   // Set leaves the FIFO with its last subchannel.
   assign o_pop         = o_issue && last_subch;
   assign o_root_start  = (state == DRAIN) && i_energy_done;

   // Every issue reads the FIFO head, so a set must be waiting there.
   a_issue_head: assert property (@(posedge clk) disable iff (!i_arst_n)
      o_issue |-> !i_fifo_empty)
      else $error("update_sequencer: issue without a set at the head");

endmodule

`default_nettype wire

/* rtl/root_iter_timer.sv */
// Counter that paces the square root iterations and flags the last one.
`timescale 1ns/1ps
`default_nettype none

module root_iter_timer (
   input  wire  clk,
   input  wire  i_arst_n,
   input  wire  i_start,
   output logic o_step,
   output logic o_last
);
   import track_ctrl_pkg::*;

   typedef logic [$clog2(ROOT_ITERS+1)-1:0] iter_cnt_t;

   iter_cnt_t count;

   // Counts down the iterations that remain.
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         count <= '0;
      end else if (i_start) begin
         count <= iter_cnt_t'(ROOT_ITERS);
      end else if (count != '0) begin
         count <= count - 1'b1;
      end
   end

   assign o_step = (count != '0);
   assign o_last = (count == iter_cnt_t'(1));

   // The sequencer waits for o_last before it can start again.
   a_start_idle: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_start |-> !o_step)
      else $error("root_iter_timer: start while iterating");

endmodule

`default_nettype wire

/* rtl/energy_pipe.sv */
// Subchannel select, magnitudes, squares and I2+Q2 capture per subchannel.
`timescale 1ns/1ps
`default_nettype none

module energy_pipe (
   input  wire                                         clk,
   input  wire                                         i_arst_n,
   input  wire  [track_width_pkg::ACC_SET_WIDTH-1:0]   i_head,
   input  wire                                         i_issue,
   input  wire  track_ctrl_pkg::subch_t                i_subch,
   input  wire                                         i_capture_tag,
   output track_width_pkg::energy_t                    o_energy_early,
   output track_width_pkg::energy_t                    o_energy_prompt,
   output track_width_pkg::energy_t                    o_energy_late,
   output track_width_pkg::tag_t                       o_tag,
   output logic                                        o_energy_done
);
   import track_width_pkg::*;
   import track_ctrl_pkg::*;

   acc_t    i_sel;
   acc_t    q_sel;
   mag_t    i_mag;
   mag_t    q_mag;
   energy_t i_sq;
   energy_t q_sq;
   logic    sq_valid;
   subch_t  sq_subch;
   energy_t sum;
   logic    sum_valid;
   subch_t  sum_subch;

   // Absolute value. Only the most negative input needs the saturation.
   function automatic mag_t abs_sat(acc_t value);
      logic [ACC_WIDTH-1:0] pos;
      pos = value[ACC_WIDTH-1] ? -value : value;
      return pos[ACC_WIDTH-1] ? {MAG_WIDTH{1'b1}} : pos[MAG_WIDTH-1:0];
   endfunction

   // Head fields from the top: tag, then early, prompt, late as I then Q.
   always_comb begin
      case (i_subch)
         2'd0: begin
            i_sel = i_head[5*ACC_WIDTH +: ACC_WIDTH];
            q_sel = i_head[4*ACC_WIDTH +: ACC_WIDTH];
         end
         2'd1: begin
            i_sel = i_head[3*ACC_WIDTH +: ACC_WIDTH];
            q_sel = i_head[2*ACC_WIDTH +: ACC_WIDTH];
         end
         default: begin
            i_sel = i_head[ACC_WIDTH +: ACC_WIDTH];
            q_sel = i_head[0 +: ACC_WIDTH];
         end
      endcase
   end

   assign i_mag = abs_sat(i_sel);
   assign q_mag = abs_sat(q_sel);

   //////////////////////////////
   // Pipeline control
   //////////////////////////////

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         sq_valid      <= 1'b0;
         sum_valid     <= 1'b0;
         o_energy_done <= 1'b0;
      end else begin
         sq_valid      <= i_issue;
         sum_valid     <= sq_valid;
         o_energy_done <= sum_valid && (sum_subch == subch_t'(SUBCH_COUNT - 1));
      end
   end

   //////////////////////////////
   // Datapath
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (i_issue) begin
         i_sq     <= energy_t'(i_mag) * energy_t'(i_mag);
         q_sq     <= energy_t'(q_mag) * energy_t'(q_mag);
         sq_subch <= i_subch;
      end
      if (sq_valid) begin
         sum       <= i_sq + q_sq;
         sum_subch <= sq_subch;
      end
      if (sum_valid) begin
         case (sum_subch)
            2'd0:    o_energy_early  <= sum;
            2'd1:    o_energy_prompt <= sum;
            default: o_energy_late   <= sum;
         endcase
      end
      // Tag holds until the next update.
      if (i_capture_tag) begin
         o_tag <= i_head[ACC_SET_WIDTH-1 -: TAG_WIDTH];
      end
   end

endmodule

`default_nettype wire

/* rtl/envelope_root.sv */
// One lane of the restoring integer square root, one result bit per step.
`timescale 1ns/1ps
`default_nettype none

module envelope_root (
   input  wire                       clk,
   input  wire                       i_arst_n,
   input  wire                       i_load,
   input  wire                       i_step,
   input  wire                       [track_width_pkg::ENERGY_WIDTH-1:0] i_energy,
   output track_width_pkg::env_t     o_root
);
   import track_width_pkg::*;

   logic [2*ENV_WIDTH-1:0] radicand;
   logic [ENV_WIDTH-1:0]   rem;
   env_t                   root;
   logic [ENV_WIDTH+1:0]   rem_shift;
   logic [ENV_WIDTH+1:0]   trial;
   logic [ENV_WIDTH+1:0]   rem_diff;
   logic                   fits;

   // Bring down the next two radicand bits.
   assign rem_shift = {rem, radicand[2*ENV_WIDTH-1 -: 2]};
   // Trial subtrahend is 4q+1.
   assign trial     = {root, 2'b01};
   assign fits      = (rem_shift >= trial);
   assign rem_diff  = rem_shift - trial;

   // Radicand shifts out two bits per step.
   always_ff @(posedge clk) begin
      if (i_load) begin
         radicand <= {{(2*ENV_WIDTH-ENERGY_WIDTH){1'b0}}, i_energy};
      end else if (i_step) begin
         radicand <= {radicand[2*ENV_WIDTH-3:0], 2'b00};
      end
   end

   //////////////////////////////
   // Remainder and root
   //////////////////////////////

   // Remainder stays at or below twice the partial root, so it fits
   // in ENV_WIDTH bits up to the last step.
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         rem  <= '0;
         root <= '0;
      end else if (i_load) begin
         rem  <= '0;
         root <= '0;
      end else if (i_step) begin
         if (fits) begin
            rem  <= rem_diff[ENV_WIDTH-1:0];
            root <= {root[ENV_WIDTH-2:0], 1'b1};
         end else begin
            rem  <= rem_shift[ENV_WIDTH-1:0];
            root <= {root[ENV_WIDTH-2:0], 1'b0};
         end
      end
   end

   assign o_root = root;

endmodule

`default_nettype wire

/* rtl/correlator_envelope.sv */
// Top level of the envelope front end: FIFO, sequencer, timer, energy pipe, roots.
`timescale 1ns/1ps
`default_nettype none

module correlator_envelope (
   input  wire                          clk,
   input  wire                          i_arst_n,
   input  wire                          i_acc_valid,
   input  wire  track_width_pkg::tag_t  i_acc_tag,
   input  wire  track_width_pkg::acc_t  i_i_early,
   input  wire  track_width_pkg::acc_t  i_q_early,
   input  wire  track_width_pkg::acc_t  i_i_prompt,
   input  wire  track_width_pkg::acc_t  i_q_prompt,
   input  wire  track_width_pkg::acc_t  i_i_late,
   input  wire  track_width_pkg::acc_t  i_q_late,
   output logic                         o_env_valid,
   output track_width_pkg::tag_t        o_env_tag,
   output track_width_pkg::env_t        o_env_early,
   output track_width_pkg::env_t        o_env_prompt,
   output track_width_pkg::env_t        o_env_late,
   output logic                         o_acc_overflow
);
   import track_width_pkg::*;
   import track_ctrl_pkg::*;

   logic [ACC_SET_WIDTH-1:0] head;
   logic                     fifo_empty;
   logic                     pop;
   logic                     issue;
   subch_t                   subch;
   logic                     capture_tag;
   logic                     energy_done;
   logic                     root_start;
   logic                     step;
   logic                     last;
   energy_t                  energy_early;
   energy_t                  energy_prompt;
   energy_t                  energy_late;

   // Fixed field order: tag, then early, prompt, late as I then Q.
   acc_fifo u_fifo (
      .i_arst_n   (i_arst_n),
      .clk        (clk),
      .i_push     (i_acc_valid),
      .i_data     ({i_acc_tag, i_i_early, i_q_early, i_i_prompt, i_q_prompt,
                    i_i_late, i_q_late}),
      .i_pop      (pop),
      .o_head     (head),
      .o_empty    (fifo_empty),
      .o_overflow (o_acc_overflow)
   );

   update_sequencer u_seq (
      .clk           (clk),
      .i_arst_n      (i_arst_n),
      .i_fifo_empty  (fifo_empty),
      .i_energy_done (energy_done),
      .i_root_last   (last),
      .o_pop         (pop),
      .o_issue       (issue),
      .o_subch       (subch),
      .o_capture_tag (capture_tag),
      .o_root_start  (root_start),
      .o_env_valid   (o_env_valid)
   );

   root_iter_timer u_timer (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_start  (root_start),
      .o_step   (step),
      .o_last   (last)
   );

   energy_pipe u_energy (
      .clk             (clk),
      .i_arst_n        (i_arst_n),
      .i_head          (head),
      .i_issue         (issue),
      .i_subch         (subch),
      .i_capture_tag   (capture_tag),
      .o_energy_early  (energy_early),
      .o_energy_prompt (energy_prompt),
      .o_energy_late   (energy_late),
      .o_tag           (o_env_tag),
      .o_energy_done   (energy_done)
   );

   // The three lanes run in lock step off the shared timer.
   envelope_root root_early (
      .clk (clk), .i_arst_n (i_arst_n), .i_load (root_start), .i_step (step),
      .i_energy (energy_early), .o_root (o_env_early)
   );

   envelope_root root_prompt (
      .clk (clk), .i_arst_n (i_arst_n), .i_load (root_start), .i_step (step),
      .i_energy (energy_prompt), .o_root (o_env_prompt)
   );

   envelope_root root_late (
      .clk (clk), .i_arst_n (i_arst_n), .i_load (root_start), .i_step (step),
      .i_energy (energy_late), .o_root (o_env_late)
   );

endmodule

`default_nettype wire

/* include/tb_envelope_model.svh */
// Model functions for accumulation magnitude, energy and integer square root.
`ifndef TB_ENVELOPE_MODEL_SVH
`define TB_ENVELOPE_MODEL_SVH

// Magnitude of one accumulation. The most negative value saturates to
// the largest magnitude, the same as the datapath.
function automatic track_width_pkg::mag_t model_mag(track_width_pkg::acc_t value);
   longint v;
   longint limit;
   limit = (longint'(1) <<< track_width_pkg::MAG_WIDTH) - 1;
   v = value;
   if (v < 0) begin
      v = -v;
   end
   if (v > limit) begin
      v = limit;
   end
   return track_width_pkg::mag_t'(v);
endfunction

// |I|^2 + |Q|^2.
function automatic track_width_pkg::energy_t model_energy(track_width_pkg::acc_t i_val,
                                                          track_width_pkg::acc_t q_val);
   longint unsigned mi;
   longint unsigned mq;
   mi = model_mag(i_val);
   mq = model_mag(q_val);
   return track_width_pkg::energy_t'(mi * mi + mq * mq);
endfunction

// Floor of the square root, built one bit at a time from the top.
function automatic track_width_pkg::env_t model_isqrt(track_width_pkg::energy_t energy);
   longint unsigned root;
   longint unsigned cand;
   root = 0;
   for (int b = track_width_pkg::ENV_WIDTH - 1; b >= 0; b--) begin
      cand = root | (longint'(1) << b);
      if (cand * cand <= energy) begin
         root = cand;
      end
   end
   return track_width_pkg::env_t'(root);
endfunction

`endif

/* bench/tb_correlator_envelope.sv */
// Testbench for the correlator envelope front end: clock, reset, watchdog, directed tests.
`timescale 1ns/1ps
`default_nettype none

module tb_correlator_envelope;
   import track_width_pkg::*;
   import track_ctrl_pkg::*;

   `include "tb_envelope_model.svh"

   localparam int CLK_PERIOD = 40;
   localparam int NUM_SETS = 24;
   localparam int WATCHDOG_CYCLES = NUM_SETS * 40 + 400;
   localparam int EXP_WIDTH = TAG_WIDTH + 3 * ENV_WIDTH;

   logic  clk;
   logic  i_arst_n;
   logic  i_acc_valid;
   tag_t  i_acc_tag;
   acc_t  i_i_early;
   acc_t  i_q_early;
   acc_t  i_i_prompt;
   acc_t  i_q_prompt;
   acc_t  i_i_late;
   acc_t  i_q_late;
   logic  o_env_valid;
   tag_t  o_env_tag;
   env_t  o_env_early;
   env_t  o_env_prompt;
   env_t  o_env_late;
   logic  o_acc_overflow;

   logic [EXP_WIDTH-1:0] exp_q[$];
   logic [EXP_WIDTH-1:0] exp_entry;
   int errors;
   int checks;
   int tests_run;
   int errors_at_start;
   int overflow_seen;

   correlator_envelope dut (
      .clk            (clk),
      .i_arst_n       (i_arst_n),
      .i_acc_valid    (i_acc_valid),
      .i_acc_tag      (i_acc_tag),
      .i_i_early      (i_i_early),
      .i_q_early      (i_q_early),
      .i_i_prompt     (i_i_prompt),
      .i_q_prompt     (i_q_prompt),
      .i_i_late       (i_i_late),
      .i_q_late       (i_q_late),
      .o_env_valid    (o_env_valid),
      .o_env_tag      (o_env_tag),
      .o_env_early    (o_env_early),
      .o_env_prompt   (o_env_prompt),
      .o_env_late     (o_env_late),
      .o_acc_overflow (o_acc_overflow)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("sim failed");
      $finish;
   end

   //////////////////////////////
   // Helpers
   //////////////////////////////

   function automatic logic [EXP_WIDTH-1:0] make_expected(tag_t tag, acc_t ie, acc_t qe,
                                                          acc_t ip, acc_t qp,
                                                          acc_t il, acc_t ql);
      return {tag, model_isqrt(model_energy(ie, qe)), model_isqrt(model_energy(ip, qp)),
              model_isqrt(model_energy(il, ql))};
   endfunction

   task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   // Outputs are sampled mid-cycle, away from the rising edge.
   always @(negedge clk) begin
      if (o_acc_overflow === 1'b1) begin
         overflow_seen++;
      end
      if (o_env_valid === 1'b1) begin
         if (exp_q.size() == 0) begin
            $display("o_env_valid strobe arrived with no accepted set outstanding");
            errors++;
         end else begin
            exp_entry = exp_q.pop_front();
            compare("o_env_tag", o_env_tag, exp_entry[EXP_WIDTH-1 -: TAG_WIDTH]);
            compare("o_env_early", o_env_early, exp_entry[2*ENV_WIDTH +: ENV_WIDTH]);
            compare("o_env_prompt", o_env_prompt, exp_entry[ENV_WIDTH +: ENV_WIDTH]);
            compare("o_env_late", o_env_late, exp_entry[0 +: ENV_WIDTH]);
         end
      end
   end

   task automatic send_set(input tag_t tag, input acc_t ie, input acc_t qe, input acc_t ip,
                           input acc_t qp, input acc_t il, input acc_t ql, input bit accepted);
      @(posedge clk);
      #2;
      i_acc_valid = 1'b1;
      i_acc_tag   = tag;
      i_i_early   = ie;
      i_q_early   = qe;
      i_i_prompt  = ip;
      i_q_prompt  = qp;
      i_i_late    = il;
      i_q_late    = ql;
      if (accepted) begin
         exp_q.push_back(make_expected(tag, ie, qe, ip, qp, il, ql));
      end
   endtask

   task automatic send_random(input bit accepted);
      acc_t v[6];
      tag_t tag;
      for (int k = 0; k < 6; k++) begin
         v[k] = acc_t'($urandom);
      end
      tag = tag_t'($urandom);
      send_set(tag, v[0], v[1], v[2], v[3], v[4], v[5], accepted);
   endtask

   task automatic release_input();
      @(posedge clk);
      #2;
      i_acc_valid = 1'b0;
   endtask

   // Waits for every outstanding result, then a few idle cycles for stray strobes.
   task automatic wait_results();
      int limit;
      int n;
      limit = exp_q.size() * 40 + 40;
      n = 0;
      while (exp_q.size() != 0 && n < limit) begin
         @(posedge clk);
         n++;
      end
      if (exp_q.size() != 0) begin
         $display("timed out with %0d results still missing", exp_q.size());
         errors++;
         exp_q.delete();
      end
      repeat (4) @(posedge clk);
   endtask

   task automatic start_test();
      errors_at_start = errors;
      overflow_seen = 0;
   endtask

   task automatic end_test(input string name, input int exp_overflow);
      compare("o_acc_overflow pulses", overflow_seen, exp_overflow);
      $display("%s: done, %0d errors", name, errors - errors_at_start);
      tests_run++;
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   task automatic test_known_values();
      start_test();
      // Idle stretch; a stray strobe or overflow shows up in the monitor.
      repeat (6) @(posedge clk);
      send_set(2'd1, '0, '0, '0, '0, '0, '0, 1'b1);
      release_input();
      wait_results();
      send_set(2'd2, 19'sd3, -19'sd4, -19'sd3, 19'sd4, 19'sd0, -19'sd5, 1'b1);
      release_input();
      wait_results();
      end_test("known_values", 0);
   endtask

   task automatic test_extremes();
      acc_t lo;
      acc_t hi;
      lo = acc_t'(1 << (ACC_WIDTH - 1));
      hi = ~lo;
      start_test();
      send_set(2'd3, lo, lo, lo, lo, lo, lo, 1'b1);
      release_input();
      wait_results();
      send_set(2'd0, hi, hi, hi, hi, hi, hi, 1'b1);
      release_input();
      wait_results();
      send_set(2'd1, lo, hi, hi, lo, lo, '0, 1'b1);
      release_input();
      wait_results();
      end_test("extremes", 0);
   endtask

   task automatic test_random_gaps();
      start_test();
      for (int k = 0; k < 8; k++) begin
         send_random(1'b1);
         release_input();
         repeat (24 + $urandom % 16) @(posedge clk);
      end
      wait_results();
      end_test("random_gaps", 0);
   endtask

   task automatic test_full_burst();
      start_test();
      for (int k = 0; k < FIFO_DEPTH; k++) begin
         send_random(1'b1);
      end
      release_input();
      wait_results();
      end_test("full_burst", 0);
   endtask

   task automatic test_overflow_burst();
      int waiting;
      int lost;
      bit accepted;
      start_test();
      send_random(1'b1);
      release_input();
      // First set is popped by now and its root iterations outlast the burst.
      repeat (10) @(posedge clk);
      waiting = 0;
      lost = 0;
      for (int k = 0; k < FIFO_DEPTH + 2; k++) begin
         accepted = (waiting < FIFO_DEPTH);
         if (accepted) begin
            waiting++;
         end else begin
            lost++;
         end
         send_random(accepted);
      end
      release_input();
      wait_results();
      end_test("overflow_burst", lost);
   endtask

   initial begin
      void'($urandom(41));
      errors      = 0;
      checks      = 0;
      tests_run   = 0;
      i_arst_n    = 1'b0;
      i_acc_valid = 1'b0;
      i_acc_tag   = '0;
      i_i_early   = '0;
      i_q_early   = '0;
      i_i_prompt  = '0;
      i_q_prompt  = '0;
      i_i_late    = '0;
      i_q_late    = '0;
      repeat (2) @(posedge clk);
      #2;
      i_arst_n = 1'b1;

      test_known_values();
      test_extremes();
      test_random_gaps();
      test_full_burst();
      test_overflow_burst();

      $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
rtl/track_width_pkg.sv
rtl/track_ctrl_pkg.sv
rtl/acc_fifo.sv
rtl/update_sequencer.sv
rtl/root_iter_timer.sv
rtl/energy_pipe.sv
rtl/envelope_root.sv
rtl/correlator_envelope.sv
bench/tb_correlator_envelope.sv
